//--- fedp_pkg.sv
package fedp_pkg;

    // Operand row size in 32-bit words
    localparam int N_WORDS = 2;

    // Source element formats (fmt_s), unknown codes fall back to FMT_I8
    localparam logic [3:0] FMT_I8 = 4'd0;
    localparam logic [3:0] FMT_U8 = 4'd1;
    localparam logic [3:0] FMT_I4 = 4'd2;
    localparam logic [3:0] FMT_U4 = 4'd3;

    // Destination formats (fmt_d), unknown codes wrap
    localparam logic [3:0] FMT_D_WRAP = 4'd0;
    localparam logic [3:0] FMT_D_SAT  = 4'd1;

    // Element slots per word, eight nibbles or four bytes
    localparam int MAX_ELEMS = 8;

    // Elements are widened to 9 bits so unsigned bytes stay positive
    localparam int ELEM_W = 9;

    // Four u8 products reach 260100, so 20 signed bits per word
    localparam int WORD_SUM_W = 20;

    // Wide signed accumulator
    localparam int ACC_W = 40;

    // Adder tree: one leaf per word plus c_val, padded to a power of two
    localparam int ACC_TERMS  = N_WORDS + 1;
    localparam int ACC_LEVELS = $clog2(ACC_TERMS);
    localparam int ACC_LEAVES = 1 << ACC_LEVELS;

    // Saturation bounds at accumulator width
    localparam logic signed [ACC_W-1:0] INT32_MAX = 40'sh00_7FFF_FFFF;
    localparam logic signed [ACC_W-1:0] INT32_MIN = 40'shFF_8000_0000;

endpackage

//--- fedp_mul.sv
module fedp_mul (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 enable,
    input  logic [fedp_pkg::N_WORDS-1:0][31:0]                   a_row,
    input  logic [fedp_pkg::N_WORDS-1:0][31:0]                   b_col,
    input  logic [3:0]                                           fmt_s,
    input  logic [fedp_pkg::N_WORDS-1:0]                         vld_mask,
    output logic [fedp_pkg::N_WORDS-1:0][fedp_pkg::WORD_SUM_W-1:0] word_sums
);
    import fedp_pkg::*;

    logic is_nib;
    logic is_sgn;
    logic [N_WORDS-1:0][WORD_SUM_W-1:0] word_sum_c;

    // Pick element idx from a word and extend it to ELEM_W bits
    function automatic logic signed [ELEM_W-1:0] elem_ext(
        input logic [31:0] word,
        input int          idx,
        input logic        nib,
        input logic        sgn
    );
        logic [3:0] n;
        logic [7:0] b;
        logic signed [ELEM_W-1:0] res;
        n = word[idx*4 +: 4];
        b = word[(idx % 4)*8 +: 8];
        if (nib) begin
            res = sgn ? {{(ELEM_W-4){n[3]}}, n} : {{(ELEM_W-4){1'b0}}, n};
        end else if (idx < 4) begin
            res = sgn ? {b[7], b} : {1'b0, b};
        end else begin
            // Bytes only fill the lower four slots
            res = '0;
        end
        return res;
    endfunction

    // Format decode
    assign is_nib = (fmt_s == FMT_I4) || (fmt_s == FMT_U4);
    assign is_sgn = !((fmt_s == FMT_U8) || (fmt_s == FMT_U4));

    always_comb begin
        logic signed [WORD_SUM_W-1:0] sum;
        logic signed [ELEM_W-1:0] ea;
        logic signed [ELEM_W-1:0] eb;
        for (int w = 0; w < N_WORDS; w++) begin
            sum = '0;
            for (int e = 0; e < MAX_ELEMS; e++) begin
                ea = elem_ext(a_row[w], e, is_nib, is_sgn);
                eb = elem_ext(b_col[w], e, is_nib, is_sgn);
                sum = sum + ea * eb;
            end
            word_sum_c[w] = sum;
        end
    end

    // Masked-out words load zero so stage 2 can add every lane blindly
    always_ff @(posedge clk) begin
        if (reset) begin
            word_sums <= '0;
        end else if (enable) begin
            for (int w = 0; w < N_WORDS; w++) begin
                word_sums[w] <= vld_mask[w] ? word_sum_c[w] : '0;
            end
        end
    end

endmodule

//--- fedp_acc.sv
module fedp_acc (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   enable,
    input  logic [fedp_pkg::N_WORDS-1:0][fedp_pkg::WORD_SUM_W-1:0] word_sums,
    input  logic [31:0]                                            c_val,
    output logic signed [fedp_pkg::ACC_W-1:0]                      acc_sum
);
    import fedp_pkg::*;

    // Heap-ordered tree, node i sums nodes 2i and 2i+1
    logic signed [ACC_W-1:0] tree [1:2*ACC_LEAVES-1];

    always_comb begin
        for (int i = 0; i < ACC_LEAVES; i++) begin
            if (i < N_WORDS) begin
                tree[ACC_LEAVES+i] = ACC_W'($signed(word_sums[i]));
            end else if (i == N_WORDS) begin
                tree[ACC_LEAVES+i] = ACC_W'($signed(c_val));
            end else begin
                tree[ACC_LEAVES+i] = '0;
            end
        end
        for (int i = ACC_LEAVES - 1; i >= 1; i--) begin
            tree[i] = tree[2*i] + tree[2*i+1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_sum <= '0;
        end else if (enable) begin
            acc_sum <= tree[1];
        end
    end

endmodule

//--- fedp_norm.sv
module fedp_norm (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic signed [fedp_pkg::ACC_W-1:0] acc_sum,
    input  logic [3:0]                        fmt_d,
    output logic [31:0]                       d_val
);
    import fedp_pkg::*;

    logic        sat_mode;
    logic        over;
    logic        under;
    logic [31:0] clamped;
    logic [31:0] d_next;

    assign sat_mode = (fmt_d == FMT_D_SAT);

    // Range check against the signed 32-bit limits
    assign over  = acc_sum > INT32_MAX;
    assign under = acc_sum < INT32_MIN;

    always_comb begin
        if (over) begin
            clamped = INT32_MAX[31:0];
        end else if (under) begin
            clamped = INT32_MIN[31:0];
        end else begin
            clamped = acc_sum[31:0];
        end
    end

    // Wrap just keeps the low word
    assign d_next = sat_mode ? clamped : acc_sum[31:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            d_val <= '0;
        end else if (enable) begin
            d_val <= d_next;
        end
    end

endmodule

//--- fedp_dot.sv
module fedp_dot (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 enable,
    input  logic [fedp_pkg::N_WORDS-1:0]         vld_mask,
    input  logic [3:0]                           fmt_s,
    input  logic [3:0]                           fmt_d,
    input  logic [fedp_pkg::N_WORDS-1:0][31:0]   a_row,
    input  logic [fedp_pkg::N_WORDS-1:0][31:0]   b_col,
    input  logic [31:0]                          c_val,
    output logic [31:0]                          d_val,
    output logic                                 d_valid
);
    import fedp_pkg::*;

    logic [2:0]                         vld_pipe;
    logic [31:0]                        c_val_r;
    logic [1:0][3:0]                    fmt_d_pipe;
    logic [N_WORDS-1:0][WORD_SUM_W-1:0] word_sums;
    logic signed [ACC_W-1:0]            acc_sum;

    // Control side: valid, c_val aligned to stage 1, fmt_d aligned to stage 3
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe   <= '0;
            c_val_r    <= '0;
            fmt_d_pipe <= '0;
        end else if (enable) begin
            vld_pipe   <= {vld_pipe[1:0], |vld_mask};
            c_val_r    <= c_val;
            fmt_d_pipe <= {fmt_d_pipe[0], fmt_d};
        end
    end

    assign d_valid = vld_pipe[2];

    // Stage 1
    fedp_mul fedp_mul_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .a_row     (a_row),
        .b_col     (b_col),
        .fmt_s     (fmt_s),
        .vld_mask  (vld_mask),
        .word_sums (word_sums)
    );

    // Stage 2
    fedp_acc fedp_acc_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .word_sums (word_sums),
        .c_val     (c_val_r),
        .acc_sum   (acc_sum)
    );

    // Stage 3
    fedp_norm fedp_norm_inst (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .acc_sum (acc_sum),
        .fmt_d   (fmt_d_pipe[1]),
        .d_val   (d_val)
    );

endmodule

//--- fedp_assertions.sv
module fedp_assertions (
    input logic        clk,
    input logic        reset,
    input logic        enable,
    input logic [31:0] d_val,
    input logic        d_valid
);

    int assert_errors = 0;

    // Output is cleared by reset and stays clear on the edge after it
    property p_reset_clears;
        @(posedge clk) reset |=> (!d_valid && d_val == 32'd0);
    endproperty

    // A stalled pipeline holds its result
    property p_stall_holds;
        @(posedge clk) disable iff (reset)
            !enable |=> ($stable(d_val) && $stable(d_valid));
    endproperty

    // A delivered result is never undefined
    property p_valid_known;
        @(posedge clk) disable iff (reset)
            d_valid |-> !$isunknown(d_val);
    endproperty

    a_reset_clears: assert property (p_reset_clears)
        else begin
            $error("d_valid or d_val not cleared by reset");
            assert_errors = assert_errors + 1;
        end

    a_stall_holds: assert property (p_stall_holds)
        else begin
            $error("d_val or d_valid changed while enable was low");
            assert_errors = assert_errors + 1;
        end

    a_valid_known: assert property (p_valid_known)
        else begin
            $error("d_val has unknown bits while d_valid is high");
            assert_errors = assert_errors + 1;
        end

endmodule

//--- tb_fedp.sv
module tb_fedp;
    import fedp_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int T1_CYCLES    = 3;
    localparam int N_PER_FMT    = 16;
    localparam int T2_CYCLES    = 4 * N_PER_FMT;
    localparam int T3_CYCLES    = 22;
    localparam int T4_CYCLES    = 8;
    localparam int T5_CYCLES    = 40;
    localparam int DRAIN_CYCLES = 6;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                + T4_CYCLES + T5_CYCLES + 5 * (DRAIN_CYCLES + 2) + 50;

    logic                      clk;
    logic                      reset;
    logic                      enable;
    logic [N_WORDS-1:0]        vld_mask;
    logic [3:0]                fmt_s;
    logic [3:0]                fmt_d;
    logic [N_WORDS-1:0][31:0]  a_row;
    logic [N_WORDS-1:0][31:0]  b_col;
    logic [31:0]               c_val;
    logic [31:0]               d_val;
    logic                      d_valid;

    logic [31:0] exp_q[$];
    int          stamp_q[$];
    int          en_edges     = 0;
    int          cycle_count  = 0;
    int          err_count    = 0;
    int          check_count  = 0;
    int          results_seen = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    fedp_dot fedp_dot_inst (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .vld_mask (vld_mask),
        .fmt_s    (fmt_s),
        .fmt_d    (fmt_d),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_val    (c_val),
        .d_val    (d_val),
        .d_valid  (d_valid)
    );

    bind fedp_dot fedp_assertions fedp_assertions_inst (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .d_val   (d_val),
        .d_valid (d_valid)
    );

    always #50 clk = ~clk;

    // Dot product of the masked words plus c_val with wrap or clamp
    function automatic logic [31:0] fedp_ref(
        input logic [N_WORDS-1:0][31:0] a,
        input logic [N_WORDS-1:0][31:0] b,
        input logic [31:0]              c,
        input logic [3:0]               fs,
        input logic [3:0]               fd,
        input logic [N_WORDS-1:0]       mask
    );
        longint sum;
        int     width;
        int     ea;
        int     eb;
        bit     sgn;
        case (fs)
            FMT_U8: begin
                width = 8;
                sgn   = 1'b0;
            end
            FMT_I4: begin
                width = 4;
                sgn   = 1'b1;
            end
            FMT_U4: begin
                width = 4;
                sgn   = 1'b0;
            end
            default: begin
                width = 8;
                sgn   = 1'b1;
            end
        endcase
        sum = longint'($signed(c));
        for (int w = 0; w < N_WORDS; w++) begin
            if (mask[w]) begin
                for (int e = 0; e < 32 / width; e++) begin
                    ea = int'((a[w] >> (e * width)) & ((32'd1 << width) - 1));
                    eb = int'((b[w] >> (e * width)) & ((32'd1 << width) - 1));
                    if (sgn && ea >= (1 << (width - 1))) begin
                        ea = ea - (1 << width);
                    end
                    if (sgn && eb >= (1 << (width - 1))) begin
                        eb = eb - (1 << width);
                    end
                    sum = sum + longint'(ea) * longint'(eb);
                end
            end
        end
        if (fd == FMT_D_SAT) begin
            if (sum > longint'(INT32_MAX)) begin
                sum = longint'(INT32_MAX);
            end
            if (sum < longint'(INT32_MIN)) begin
                sum = longint'(INT32_MIN);
            end
        end
        return sum[31:0];
    endfunction

    // Check the output first, then record the request taken on this edge
    always @(posedge clk) begin
        logic [31:0] exp_val;
        int          stamp;
        if (!reset && enable) begin
            en_edges = en_edges + 1;
            if (d_valid) begin
                results_seen = results_seen + 1;
                if (exp_q.size() == 0) begin
                    $display("Error at time %0t: d_valid high with no request outstanding",
                             $time);
                    err_count = err_count + 1;
                end else begin
                    exp_val     = exp_q.pop_front();
                    stamp       = stamp_q.pop_front();
                    check_count = check_count + 1;
                    if (d_val !== exp_val) begin
                        $display("Fail at time %0t: d_val got %h expected %h",
                                 $time, d_val, exp_val);
                        err_count = err_count + 1;
                    end
                    if (en_edges - stamp != 3) begin
                        $display("Fail at time %0t: latency got %0d expected 3",
                                 $time, en_edges - stamp);
                        err_count = err_count + 1;
                    end
                end
            end
            if (|vld_mask) begin
                exp_q.push_back(fedp_ref(a_row, b_col, c_val, fmt_s, fmt_d, vld_mask));
                stamp_q.push_back(en_edges);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic drive(
        input logic                     en,
        input logic [N_WORDS-1:0]       mask,
        input logic [3:0]               fs,
        input logic [3:0]               fd,
        input logic [N_WORDS-1:0][31:0] a,
        input logic [N_WORDS-1:0][31:0] b,
        input logic [31:0]              c
    );
        @(posedge clk);
        enable   <= en;
        vld_mask <= mask;
        fmt_s    <= fs;
        fmt_d    <= fd;
        a_row    <= a;
        b_col    <= b;
        c_val    <= c;
    endtask

    task automatic drive_random(
        input logic               en,
        input logic [N_WORDS-1:0] mask,
        input logic [3:0]         fs,
        input logic [3:0]         fd
    );
        logic [N_WORDS-1:0][31:0] a;
        logic [N_WORDS-1:0][31:0] b;
        for (int w = 0; w < N_WORDS; w++) begin
            a[w] = $urandom();
            b[w] = $urandom();
        end
        drive(en, mask, fs, fd, a, b, $urandom());
    endtask

    // Idle inputs with enable high until every expected result is consumed
    task automatic drain;
        drive(1'b1, '0, FMT_I8, FMT_D_WRAP, '0, '0, 32'd0);
        @(posedge clk);
        for (int i = 0; i < DRAIN_CYCLES && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("Error at time %0t: %0d expected results never arrived",
                     $time, exp_q.size());
            err_count = err_count + 1;
            exp_q.delete();
            stamp_q.delete();
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("Test %0d %s: pass", num, name);
            tests_passed = tests_passed + 1;
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, err_count - errs_before);
            tests_failed = tests_failed + 1;
        end
    endtask

    initial begin
        int errs;
        int seen;
        int issued;
        logic [N_WORDS-1:0] mask;
        void'($urandom(26708));
        clk      = 1'b0;
        reset    = 1'b1;
        enable   = 1'b1;
        vld_mask = '0;
        fmt_s    = FMT_I8;
        fmt_d    = FMT_D_WRAP;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        errs = err_count;
        repeat (T1_CYCLES) begin
            @(posedge clk);
            check_count = check_count + 1;
            if (d_valid !== 1'b0) begin
                $display("Fail at time %0t: d_valid got %b expected 0", $time, d_valid);
                err_count = err_count + 1;
            end
            if (d_val !== 32'd0) begin
                $display("Fail at time %0t: d_val got %h expected 00000000", $time, d_val);
                err_count = err_count + 1;
            end
        end
        report_test(1, "reset state", errs);

        errs = err_count;
        for (int f = 0; f < 4; f++) begin
            repeat (N_PER_FMT) drive_random(1'b1, '1, 4'(f), FMT_D_WRAP);
        end
        drain();
        report_test(2, "source formats", errs);

        // Every mask pattern followed by a run of all-zero masks
        errs   = err_count;
        seen   = results_seen;
        issued = 0;
        for (int i = 0; i < 16; i++) begin
            mask = N_WORDS'(i % 4);
            if (mask != 0) begin
                issued = issued + 1;
            end
            drive_random(1'b1, mask, 4'($urandom() % 4), FMT_D_WRAP);
        end
        repeat (6) drive_random(1'b1, '0, 4'($urandom() % 4), FMT_D_SAT);
        drain();
        if (results_seen - seen != issued) begin
            $display("Error: %0d results delivered for %0d masked-in requests",
                     results_seen - seen, issued);
            err_count = err_count + 1;
        end
        report_test(3, "valid masks", errs);

        errs = err_count;
        drive(1'b1, '1, FMT_I8, FMT_D_SAT, {N_WORDS{32'h7F7F7F7F}},
              {N_WORDS{32'h7F7F7F7F}}, 32'h7FFF_FFF0);
        drive(1'b1, '1, FMT_I8, FMT_D_WRAP, {N_WORDS{32'h7F7F7F7F}},
              {N_WORDS{32'h7F7F7F7F}}, 32'h7FFF_FFF0);
        drive(1'b1, '1, FMT_I8, FMT_D_SAT, {N_WORDS{32'h80808080}},
              {N_WORDS{32'h7F7F7F7F}}, 32'h8000_0010);
        drive(1'b1, '1, FMT_I8, FMT_D_WRAP, {N_WORDS{32'h80808080}},
              {N_WORDS{32'h7F7F7F7F}}, 32'h8000_0010);
        drive(1'b1, '1, FMT_U8, FMT_D_SAT, {N_WORDS{32'hFFFFFFFF}},
              {N_WORDS{32'hFFFFFFFF}}, 32'h7FFF_0000);
        // Unknown fmt_d code behaves as wrap
        drive(1'b1, '1, FMT_U8, 4'h7, {N_WORDS{32'hFFFFFFFF}},
              {N_WORDS{32'hFFFFFFFF}}, 32'h7FFF_0000);
        drive(1'b1, '1, FMT_I4, FMT_D_SAT, {N_WORDS{32'h77777777}},
              {N_WORDS{32'h77777777}}, 32'h7FFF_FF00);
        drive(1'b1, '1, FMT_I4, FMT_D_SAT, {N_WORDS{32'h88888888}},
              {N_WORDS{32'h77777777}}, 32'h8000_0100);
        drain();
        report_test(4, "saturation", errs);

        errs = err_count;
        repeat (T5_CYCLES) begin
            drive_random(($urandom() % 4) != 0, N_WORDS'(($urandom() % 3) + 1),
                         4'($urandom() % 4), 4'($urandom() % 2));
        end
        drain();
        report_test(5, "enable stalls", errs);

        if (fedp_dot_inst.fedp_assertions_inst.assert_errors != 0) begin
            $display("Error: %0d assertion failures during the run",
                     fedp_dot_inst.fedp_assertions_inst.assert_errors);
            err_count = err_count + fedp_dot_inst.fedp_assertions_inst.assert_errors;
        end
        $display("Tests: %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
fedp_pkg.sv
fedp_mul.sv
fedp_acc.sv
fedp_norm.sv
fedp_dot.sv
fedp_assertions.sv
tb_fedp.sv

//--- Bender.yml
package:
  name: fedp

sources:
  # RTL
  - files:
      - fedp_pkg.sv
      - fedp_mul.sv
      - fedp_acc.sv
      - fedp_norm.sv
      - fedp_dot.sv

  # Testbench
  - target: simulation
    files:
      - fedp_assertions.sv
      - tb_fedp.sv
